// File: list.f
rtl/mipsPkg.sv
rtl/fetchUnit.sv
rtl/decodeUnit.sv
rtl/regFile.sv
rtl/aluUnit.sv
rtl/hazardUnit.sv
rtl/datapath.sv
sim/datapathTb.sv

// File: run.sh
#!/usr/bin/env bash
# build the datapath testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --assert --timescale 1ns/1ps --top-module datapathTb \
    -Mdir obj_dir -o datapathSim -f list.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/datapathSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "Simulation finished: FAIL" "$logFile"; then
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi
if ! grep -q "Simulation finished: PASS" "$logFile"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

// File: sim/stimProgram.txt
# each line holds a tag and two hex fields
# I addr instr   D addr data   W reg value   M addr final word
I bfc00000 24010005 # addiu $1,$0,5
I bfc00004 2402fffd # addiu $2,$0,-3
I bfc00008 00221821 # addu $3,$1,$2
I bfc0000c 00612023 # subu $4,$3,$1
I bfc00010 0083282a # slt $5,$4,$3
I bfc00014 00013100 # sll $6,$1,4
I bfc00018 3c071234 # lui $7,0x1234
I bfc0001c 34e75678 # ori $7,$7,0x5678
I bfc00020 00e64026 # xor $8,$7,$6
I bfc00024 00c54825 # or $9,$6,$5
I bfc00028 00e65024 # and $10,$7,$6
I bfc0002c 30ebff0f # andi $11,$7,0xff0f
I bfc00030 ac070008 # sw $7,8($0)
I bfc00034 a001000d # sb $1,13($0)
I bfc00038 8c0c0008 # lw $12,8($0)
I bfc0003c 01816821 # addu $13,$12,$1 right after the load
I bfc00040 900e000e # lbu $14,14($0)
I bfc00044 25cf0001 # addiu $15,$14,1 right after the load
I bfc00048 10210003 # beq $1,$1 taken
I bfc0004c 24100007 # delay slot
I bfc00050 24110009 # flushed
I bfc00054 2411000a # never fetched
I bfc00058 14220002 # bne $1,$2 taken
I bfc0005c 24120011 # delay slot
I bfc00060 24130022 # flushed
I bfc00064 10220002 # beq $1,$2 not taken
I bfc00068 24140033
I bfc0006c 24150044
I bfc00070 ac0f0010 # sw $15,16($0)
D 00000008 ffffffff
D 0000000c a1b2c3d4
W 01 00000005
W 02 fffffffd
W 03 00000002
W 04 fffffffd
W 05 00000001
W 06 00000050
W 07 12340000
W 07 12345678
W 08 12345628
W 09 00000051
W 0a 00000050
W 0b 00005608
W 0c 12345678
W 0d 1234567d
W 0e 000000b2
W 0f 000000b3
W 10 00000007
W 12 00000011
W 14 00000033
W 15 00000044
M 00000008 12345678
M 0000000c a1b205d4
M 00000010 000000b3

// File: sim/datapathTb.sv
module datapathTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam mipsPkg::wordT ResetPc  = 32'hbfc0_0000;
    localparam mipsPkg::wordT RomBytes = 32'd256;
    localparam int            MemWords = 64;

    logic            clk = 1'b0;
    logic            reset;
    mipsPkg::wordT   instAddrF;
    logic            instEnF;
    mipsPkg::wordT   instrF;
    logic            iCacheStall;
    logic            memEnM;
    mipsPkg::wordT   memAddrM;
    mipsPkg::wordT   memRdataM;
    mipsPkg::byteEnT memWriteSelectM;
    mipsPkg::wordT   writeDataM;
    logic            dCacheStall;
    logic            longestStall;
    mipsPkg::wordT   debugWbPc;
    logic            debugWbRfWen;
    mipsPkg::regIdxT debugWbRfWnum;
    mipsPkg::wordT   debugWbRfWdata;

    mipsPkg::wordT   rom [MemWords];
    mipsPkg::wordT   ram [MemWords];
    mipsPkg::wordT   romOff;
    mipsPkg::regIdxT wantRegQ [$];
    mipsPkg::wordT   wantValQ [$];
    mipsPkg::wordT   memAddrQ [$];
    mipsPkg::wordT   memValQ [$];
    integer          seed = 32'h1142f99e;
    int              instCount = 0;
    int              cycleLimit = 0;
    int              cycles = 0;
    int              wbIdx = 0;
    mipsPkg::wordT   lastWbPc = ResetPc - 32'd4;
    mipsPkg::wordT   prevFetch = ResetPc;
    logic            prevEn = 1'b1;

    datapath #(.ResetPc(ResetPc)) dut0 (
        .clk(clk), .reset_i(reset), .instAddrF_o(instAddrF), .instEnF_o(instEnF),
        .instrF_i(instrF), .iCacheStall_i(iCacheStall), .memEnM_o(memEnM),
        .memAddrM_o(memAddrM), .memRdataM_i(memRdataM),
        .memWriteSelectM_o(memWriteSelectM), .writeDataM_o(writeDataM),
        .dCacheStall_i(dCacheStall), .longestStall_o(longestStall),
        .debugWbPc_o(debugWbPc), .debugWbRfWen_o(debugWbRfWen),
        .debugWbRfWnum_o(debugWbRfWnum), .debugWbRfWdata_o(debugWbRfWdata)
    );

    always #20 clk = ~clk; // 40 ns period

    assign romOff    = instAddrF - ResetPc;
    assign instrF    = (romOff < RomBytes) ? rom[romOff[7:2]] : '0; // nops past the program
    assign memRdataM = ram[memAddrM[7:2]];

    task automatic stopRun();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkWord(input string name, input mipsPkg::wordT expected,
                             input mipsPkg::wordT actual);
        if (actual !== expected) begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            stopRun();
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail %s expected %b actual %b", name, expected, actual);
            stopRun();
        end
    endtask

    task automatic checkWriteback(input string name,
                                  input mipsPkg::regIdxT wantReg, input mipsPkg::wordT wantVal,
                                  input mipsPkg::regIdxT gotReg, input mipsPkg::wordT gotVal);
        if (gotReg !== wantReg || gotVal !== wantVal) begin
            $display("Fail %s expected r%0d = %h actual r%0d = %h",
                     name, wantReg, wantVal, gotReg, gotVal);
            stopRun();
        end
    endtask

    function automatic mipsPkg::wordT mergeLanes(input mipsPkg::wordT old,
                                                 input mipsPkg::wordT data,
                                                 input mipsPkg::byteEnT sel);
        mipsPkg::wordT merged;
        merged = old;
        for (int lane = 0; lane < 4; lane++) begin
            if (sel[lane]) begin
                merged[lane*8 +: 8] = data[lane*8 +: 8];
            end
        end
        return merged;
    endfunction

    function automatic mipsPkg::wordT romWord(input mipsPkg::wordT addr);
        mipsPkg::wordT off;
        off = addr - ResetPc;
        return (off < RomBytes) ? rom[off[7:2]] : '0;
    endfunction

    // first program word after the given address that writes the register
    function automatic mipsPkg::wordT writerPc(input mipsPkg::wordT after,
                                               input mipsPkg::regIdxT dest);
        mipsPkg::wordT   pc;
        mipsPkg::wordT   word;
        mipsPkg::regIdxT target;
        mipsPkg::wordT   result;
        result = '1;
        for (pc = after + 32'd4; pc - ResetPc < RomBytes && result == '1; pc += 32'd4) begin
            word = romWord(pc);
            case (word[31:26])
                mipsPkg::OpSpecial: target = word[15:11]; // r-type names rd
                mipsPkg::OpAddiu, mipsPkg::OpAndi, mipsPkg::OpOri, mipsPkg::OpLui,
                mipsPkg::OpLw, mipsPkg::OpLbu: target = word[20:16];
                default: target = '0;
            endcase
            if (target != '0 && target == dest) begin
                result = pc;
            end
        end
        return result;
    endfunction

    // fetch two words past a beq or bne
    function automatic logic followsBranch(input mipsPkg::wordT addr);
        mipsPkg::wordT word;
        word = romWord(addr - 32'd8);
        return word[31:26] == mipsPkg::OpBeq || word[31:26] == mipsPkg::OpBne;
    endfunction

    task automatic loadStim();
        int            fd;
        int            c;
        logic [7:0]    tag;
        mipsPkg::wordT a;
        mipsPkg::wordT b;
        mipsPkg::wordT off;
        for (int i = 0; i < MemWords; i++) begin
            rom[i] = '0;
            ram[i] <= 32'h5a5a_0000 ^ mipsPkg::wordT'(i << 2); // each word tagged by its address
        end
        fd = $fopen("sim/stimProgram.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/stimProgram.txt");
            stopRun();
        end else begin
            while ($fscanf(fd, " %c", tag) == 1) begin
                if (tag == "#") begin
                    c = $fgetc(fd); // rest of the line is a comment
                    while (c != 10 && c != -1) begin
                        c = $fgetc(fd);
                    end
                end else if ($fscanf(fd, " %h %h", a, b) != 2) begin
                    $display("stim line with tag %c has no two hex fields", tag);
                    stopRun();
                end else begin
                    case (tag)
                        "I": begin
                            off = a - ResetPc;
                            rom[off[7:2]] = b;
                            instCount++;
                        end
                        "D": ram[a[7:2]] <= b;
                        "W": begin
                            wantRegQ.push_back(a[4:0]);
                            wantValQ.push_back(b);
                        end
                        "M": begin
                            memAddrQ.push_back(a);
                            memValQ.push_back(b);
                        end
                        default: begin
                            $display("unknown tag %c in the stim file", tag);
                            stopRun();
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    // store lands on the edge that moves it out of memory stage
    always @(posedge clk) begin
        if (memEnM && memWriteSelectM != '0 && !longestStall) begin
            ram[memAddrM[7:2]] <= mergeLanes(ram[memAddrM[7:2]], writeDataM, memWriteSelectM);
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            iCacheStall <= 1'b0;
            dCacheStall <= 1'b0;
        end else begin
            iCacheStall <= ($random(seed) & 3) == 0; // about one cycle in four
            dCacheStall <= ($random(seed) & 3) == 0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycleLimit > 0 && cycles > cycleLimit) begin
            $display("timeout after %0d cycles with %0d of %0d writebacks seen",
                     cycles, wbIdx, wantRegQ.size());
            stopRun();
        end
    end

    // outputs settle by the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            checkFlag("stall or", iCacheStall | dCacheStall, longestStall);
            // a jump away from sequential fetch follows a dropped fetch
            if (instAddrF != prevFetch && instAddrF != prevFetch + 32'd4) begin
                checkFlag($sformatf("fetch enable before redirect to %h", instAddrF),
                          1'b0, prevEn);
            end
            if (!followsBranch(instAddrF)) begin
                checkFlag($sformatf("fetch enable at %h", instAddrF), 1'b1, instEnF);
            end
            prevFetch = instAddrF;
            prevEn    = instEnF;
            if (debugWbRfWen) begin
                if (wbIdx >= wantRegQ.size()) begin
                    $display("writeback to r%0d after the end of the expected trace",
                             debugWbRfWnum);
                    stopRun();
                end else begin
                    checkWriteback($sformatf("writeback %0d at pc %h", wbIdx, debugWbPc),
                                   wantRegQ[wbIdx], wantValQ[wbIdx],
                                   debugWbRfWnum, debugWbRfWdata);
                    checkWord($sformatf("writeback %0d pc", wbIdx),
                              writerPc(lastWbPc, wantRegQ[wbIdx]), debugWbPc);
                    lastWbPc = debugWbPc;
                    wbIdx = wbIdx + 1;
                end
            end
        end
    end

    initial begin
        int            quiet;
        mipsPkg::wordT addr;
        reset       <= 1'b1;
        iCacheStall <= 1'b0;
        dCacheStall <= 1'b0;
        loadStim();
        cycleLimit = 6 * instCount + 40;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkWord("first fetch", ResetPc, instAddrF);
        for (int c = 0; c < 4; c++) begin
            if (c > 0) begin
                @(negedge clk);
            end
            checkFlag("no early writeback", 1'b0, debugWbRfWen);
            if (c < 3) begin
                checkFlag("no early store", 1'b0, memEnM);
            end
        end
        while (wbIdx < wantRegQ.size()) begin
            @(negedge clk);
        end
        quiet = 0; // let the last store drain
        while (quiet < 4) begin
            @(negedge clk);
            if (!longestStall) begin
                quiet++;
            end
        end
        for (int i = 0; i < memAddrQ.size(); i++) begin
            addr = memAddrQ[i];
            checkWord($sformatf("memory %h", addr), memValQ[i], ram[addr[7:2]]);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: rtl/datapath.sv
module datapath #(
    parameter mipsPkg::wordT ResetPc = 32'hbfc0_0000
) (
    input  logic            clk,
    input  logic            reset_i,
    output mipsPkg::wordT   instAddrF_o,
    output logic            instEnF_o,
    input  mipsPkg::wordT   instrF_i,
    input  logic            iCacheStall_i,
    output logic            memEnM_o,
    output mipsPkg::wordT   memAddrM_o,
    input  mipsPkg::wordT   memRdataM_i,
    output mipsPkg::byteEnT memWriteSelectM_o,
    output mipsPkg::wordT   writeDataM_o,
    input  logic            dCacheStall_i,
    output logic            longestStall_o,
    output mipsPkg::wordT   debugWbPc_o,
    output logic            debugWbRfWen_o,
    output mipsPkg::regIdxT debugWbRfWnum_o,
    output mipsPkg::wordT   debugWbRfWdata_o
);

    logic            stallF, stallD, stallE, stallM, stallW, flushD, flushE;
    mipsPkg::fwdSelT fwdSel1D, fwdSel2D;
    mipsPkg::wordT   pcD, instrD, rd1D, rd2D, srcAD, srcBD, rtValueD, branchTargetD;
    mipsPkg::regIdxT rsD, rtD, writeRegD;
    mipsPkg::aluOpT  aluOpD;
    logic            regWriteD, memReadD, memWriteD, byteAccessD, branchD, branchNeD;
    mipsPkg::wordT   pcE, aluOutE, rtValueE, branchTargetE;
    mipsPkg::regIdxT writeRegE;
    logic            regWriteE, memReadE, memWriteE, byteAccessE, takeE;
    mipsPkg::wordT   pcM, aluOutM, rtValueM, resultM;
    mipsPkg::regIdxT writeRegM;
    logic            regWriteM, memReadM, memWriteM, byteAccessM;
    logic [7:0]      loadByteM;
    mipsPkg::wordT   pcW, resultW;
    mipsPkg::regIdxT writeRegW;
    logic            regWriteW;

    fetchUnit #(.ResetPc(ResetPc)) fetch0 (
        .clk(clk), .reset_i(reset_i), .stallF_i(stallF), .stallD_i(stallD),
        .flushD_i(flushD), .takeE_i(takeE), .branchTargetE_i(branchTargetE),
        .instrF_i(instrF_i), .instAddrF_o(instAddrF_o), .instEnF_o(instEnF_o),
        .pcD_o(pcD), .instrD_o(instrD)
    );

    decodeUnit decode0 (
        .instrD_i(instrD), .pcD_i(pcD), .rd1D_i(rd1D), .rd2D_i(rd2D),
        .fwdAluE_i(aluOutE), .fwdResultM_i(resultM), .fwdResultW_i(resultW),
        .fwdSel1D_i(fwdSel1D), .fwdSel2D_i(fwdSel2D), .rsD_o(rsD), .rtD_o(rtD),
        .writeRegD_o(writeRegD), .srcAD_o(srcAD), .srcBD_o(srcBD), .rtValueD_o(rtValueD),
        .branchTargetD_o(branchTargetD), .aluOpD_o(aluOpD), .regWriteD_o(regWriteD),
        .memReadD_o(memReadD), .memWriteD_o(memWriteD), .byteAccessD_o(byteAccessD),
        .branchD_o(branchD), .branchNeD_o(branchNeD)
    );

    regFile regs0 (
        .clk(clk), .reset_i(reset_i), .stall_i(stallW), .we_i(regWriteW),
        .ra1_i(rsD), .ra2_i(rtD), .wa_i(writeRegW), .wd_i(resultW),
        .rd1_o(rd1D), .rd2_o(rd2D)
    );

    aluUnit alu0 (
        .clk(clk), .reset_i(reset_i), .stallE_i(stallE), .flushE_i(flushE),
        .srcAD_i(srcAD), .srcBD_i(srcBD), .rtValueD_i(rtValueD),
        .branchTargetD_i(branchTargetD), .writeRegD_i(writeRegD), .aluOpD_i(aluOpD),
        .regWriteD_i(regWriteD), .memReadD_i(memReadD), .memWriteD_i(memWriteD),
        .byteAccessD_i(byteAccessD), .branchD_i(branchD), .branchNeD_i(branchNeD),
        .shamtD_i(instrD[10:6]), .aluOutE_o(aluOutE), .rtValueE_o(rtValueE),
        .writeRegE_o(writeRegE), .regWriteE_o(regWriteE), .memReadE_o(memReadE),
        .memWriteE_o(memWriteE), .byteAccessE_o(byteAccessE), .takeE_o(takeE),
        .branchTargetE_o(branchTargetE)
    );

    hazardUnit hazard0 (
        .rsD_i(rsD), .rtD_i(rtD), .writeRegE_i(writeRegE), .writeRegM_i(writeRegM),
        .writeRegW_i(writeRegW), .regWriteE_i(regWriteE), .regWriteM_i(regWriteM),
        .regWriteW_i(regWriteW), .memReadE_i(memReadE), .takeE_i(takeE),
        .iCacheStall_i(iCacheStall_i), .dCacheStall_i(dCacheStall_i),
        .stallF_o(stallF), .stallD_o(stallD), .stallE_o(stallE), .stallM_o(stallM),
        .stallW_o(stallW), .flushD_o(flushD), .flushE_o(flushE),
        .longestStall_o(longestStall_o), .fwdSel1D_o(fwdSel1D), .fwdSel2D_o(fwdSel2D)
    );

    always_ff @(posedge clk) begin
        if (!stallE) begin
            pcE <= pcD; // only for the debug port
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            regWriteM   <= 1'b0;
            memReadM    <= 1'b0;
            memWriteM   <= 1'b0;
            byteAccessM <= 1'b0;
        end else if (!stallM) begin
            regWriteM   <= regWriteE;
            memReadM    <= memReadE;
            memWriteM   <= memWriteE;
            byteAccessM <= byteAccessE;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallM) begin
            pcM       <= pcE;
            aluOutM   <= aluOutE;
            rtValueM  <= rtValueE;
            writeRegM <= writeRegE;
        end
    end

    assign memEnM_o     = memReadM | memWriteM;
    assign memAddrM_o   = {aluOutM[31:2], 2'b00};
    assign writeDataM_o = byteAccessM ? {4{rtValueM[7:0]}} : rtValueM; // sb copies the byte
    assign memWriteSelectM_o = !memWriteM ? 4'b0000 :
                               byteAccessM ? 4'b0001 << aluOutM[1:0] : 4'b1111;

    assign loadByteM = memRdataM_i[{aluOutM[1:0], 3'b000} +: 8]; // little endian lanes
    assign resultM   = !memReadM ? aluOutM :
                       byteAccessM ? {24'b0, loadByteM} : memRdataM_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            regWriteW <= 1'b0;
        end else if (!stallW) begin
            regWriteW <= regWriteM;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallW) begin
            pcW       <= pcM;
            resultW   <= resultM;
            writeRegW <= writeRegM;
        end
    end

    assign debugWbPc_o      = pcW;
    assign debugWbRfWen_o   = regWriteW & ~stallW; // one pulse per retired write
    assign debugWbRfWnum_o  = writeRegW;
    assign debugWbRfWdata_o = resultW;

    // a load-use stall and a taken branch never meet in the same cycle
    noFlushWhileStalled: assert property (@(posedge clk) disable iff (reset_i || longestStall_o)
        !(flushD && stallD));

endmodule

// File: rtl/hazardUnit.sv
module hazardUnit (
    input  mipsPkg::regIdxT rsD_i,
    input  mipsPkg::regIdxT rtD_i,
    input  mipsPkg::regIdxT writeRegE_i,
    input  mipsPkg::regIdxT writeRegM_i,
    input  mipsPkg::regIdxT writeRegW_i,
    input  logic            regWriteE_i,
    input  logic            regWriteM_i,
    input  logic            regWriteW_i,
    input  logic            memReadE_i,
    input  logic            takeE_i,
    input  logic            iCacheStall_i,
    input  logic            dCacheStall_i,
    output logic            stallF_o,
    output logic            stallD_o,
    output logic            stallE_o,
    output logic            stallM_o,
    output logic            stallW_o,
    output logic            flushD_o,
    output logic            flushE_o,
    output logic            longestStall_o,
    output mipsPkg::fwdSelT fwdSel1D_o,
    output mipsPkg::fwdSelT fwdSel2D_o
);

    logic loadUse;

    // newest producer wins
    function automatic mipsPkg::fwdSelT pickSrc(input mipsPkg::regIdxT src);
        if (src == '0) begin
            return mipsPkg::FwdReg;
        end else if (regWriteE_i && writeRegE_i == src) begin
            return mipsPkg::FwdExe;
        end else if (regWriteM_i && writeRegM_i == src) begin
            return mipsPkg::FwdMem;
        end else if (regWriteW_i && writeRegW_i == src) begin
            return mipsPkg::FwdWb;
        end
        return mipsPkg::FwdReg;
    endfunction

    assign fwdSel1D_o = pickSrc(rsD_i);
    assign fwdSel2D_o = pickSrc(rtD_i);

    // load data only exists from memory on
    assign loadUse = memReadE_i && regWriteE_i &&
                     (writeRegE_i == rsD_i || writeRegE_i == rtD_i);

    assign longestStall_o = iCacheStall_i | dCacheStall_i;
    assign stallF_o       = loadUse | longestStall_o;
    assign stallD_o       = loadUse | longestStall_o;
    assign stallE_o       = longestStall_o;
    assign stallM_o       = longestStall_o;
    assign stallW_o       = longestStall_o;
    assign flushD_o       = takeE_i; // kill the fetch after the delay slot
    assign flushE_o       = loadUse; // bubble while the load moves on

endmodule

// File: rtl/aluUnit.sv
module aluUnit (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            stallE_i,
    input  logic            flushE_i,
    input  mipsPkg::wordT   srcAD_i,
    input  mipsPkg::wordT   srcBD_i,
    input  mipsPkg::wordT   rtValueD_i,
    input  mipsPkg::wordT   branchTargetD_i,
    input  mipsPkg::regIdxT writeRegD_i,
    input  mipsPkg::aluOpT  aluOpD_i,
    input  logic            regWriteD_i,
    input  logic            memReadD_i,
    input  logic            memWriteD_i,
    input  logic            byteAccessD_i,
    input  logic            branchD_i,
    input  logic            branchNeD_i,
    input  logic [4:0]      shamtD_i,
    output mipsPkg::wordT   aluOutE_o,
    output mipsPkg::wordT   rtValueE_o,
    output mipsPkg::regIdxT writeRegE_o,
    output logic            regWriteE_o,
    output logic            memReadE_o,
    output logic            memWriteE_o,
    output logic            byteAccessE_o,
    output logic            takeE_o,
    output mipsPkg::wordT   branchTargetE_o
);

    mipsPkg::wordT  srcAE;
    mipsPkg::wordT  srcBE;
    mipsPkg::aluOpT aluOpE;
    logic [4:0]     shamtE;
    logic           branchE;
    logic           branchNeE;

    // control bits, cleared into a bubble
    always_ff @(posedge clk) begin
        if (reset_i || (flushE_i && !stallE_i)) begin
            regWriteE_o   <= 1'b0;
            memReadE_o    <= 1'b0;
            memWriteE_o   <= 1'b0;
            byteAccessE_o <= 1'b0;
            branchE       <= 1'b0;
            branchNeE     <= 1'b0;
        end else if (!stallE_i) begin
            regWriteE_o   <= regWriteD_i;
            memReadE_o    <= memReadD_i;
            memWriteE_o   <= memWriteD_i;
            byteAccessE_o <= byteAccessD_i;
            branchE       <= branchD_i;
            branchNeE     <= branchNeD_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallE_i) begin
            srcAE           <= srcAD_i;
            srcBE           <= srcBD_i;
            rtValueE_o      <= rtValueD_i;
            branchTargetE_o <= branchTargetD_i;
            writeRegE_o     <= writeRegD_i;
            aluOpE          <= aluOpD_i;
            shamtE          <= shamtD_i;
        end
    end

    always_comb begin
        case (aluOpE)
            mipsPkg::AluAdd: aluOutE_o = srcAE + srcBE;
            mipsPkg::AluSub: aluOutE_o = srcAE - srcBE;
            mipsPkg::AluAnd: aluOutE_o = srcAE & srcBE;
            mipsPkg::AluOr:  aluOutE_o = srcAE | srcBE;
            mipsPkg::AluXor: aluOutE_o = srcAE ^ srcBE;
            mipsPkg::AluSlt: aluOutE_o = {31'b0, $signed(srcAE) < $signed(srcBE)};
            mipsPkg::AluSll: aluOutE_o = srcBE << shamtE; // shifts rt
            default:         aluOutE_o = {srcBE[15:0], 16'b0}; // lui
        endcase
    end

    // beq or bne, operands already forwarded in decode
    assign takeE_o = branchE && ((srcAE == rtValueE_o) ^ branchNeE);

    // a taken branch in execute carries no register write and no memory access
    takeIsBranch: assert property (@(posedge clk) disable iff (reset_i)
        takeE_o |-> (!regWriteE_o && !memReadE_o && !memWriteE_o));

endmodule

// File: rtl/regFile.sv
module regFile (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            stall_i,
    input  logic            we_i,
    input  mipsPkg::regIdxT ra1_i,
    input  mipsPkg::regIdxT ra2_i,
    input  mipsPkg::regIdxT wa_i,
    input  mipsPkg::wordT   wd_i,
    output mipsPkg::wordT   rd1_o,
    output mipsPkg::wordT   rd2_o
);

    mipsPkg::wordT regs [0:31];

    always_ff @(posedge clk) begin
        if (!reset_i && we_i && !stall_i && wa_i != '0) begin
            regs[wa_i] <= wd_i;
        end
    end

    // $0 is never written, so it is masked on read
    assign rd1_o = (ra1_i == '0) ? '0 : regs[ra1_i];
    assign rd2_o = (ra2_i == '0) ? '0 : regs[ra2_i];

endmodule

// File: rtl/decodeUnit.sv
module decodeUnit (
    input  mipsPkg::wordT   instrD_i,
    input  mipsPkg::wordT   pcD_i,
    input  mipsPkg::wordT   rd1D_i,
    input  mipsPkg::wordT   rd2D_i,
    input  mipsPkg::wordT   fwdAluE_i,
    input  mipsPkg::wordT   fwdResultM_i,
    input  mipsPkg::wordT   fwdResultW_i,
    input  mipsPkg::fwdSelT fwdSel1D_i,
    input  mipsPkg::fwdSelT fwdSel2D_i,
    output mipsPkg::regIdxT rsD_o,
    output mipsPkg::regIdxT rtD_o,
    output mipsPkg::regIdxT writeRegD_o,
    output mipsPkg::wordT   srcAD_o,
    output mipsPkg::wordT   srcBD_o,
    output mipsPkg::wordT   rtValueD_o,
    output mipsPkg::wordT   branchTargetD_o,
    output mipsPkg::aluOpT  aluOpD_o,
    output logic            regWriteD_o,
    output logic            memReadD_o,
    output logic            memWriteD_o,
    output logic            byteAccessD_o,
    output logic            branchD_o,
    output logic            branchNeD_o
);

    logic [5:0]    opcode;
    logic [5:0]    funct;
    logic          writesReg;
    logic          useImm;
    logic          signExt;
    logic          useRd;
    mipsPkg::wordT immSign;
    mipsPkg::wordT immExt;

    function automatic mipsPkg::wordT pickFwd(input mipsPkg::fwdSelT sel,
                                              input mipsPkg::wordT regVal);
        case (sel)
            mipsPkg::FwdExe: return fwdAluE_i;
            mipsPkg::FwdMem: return fwdResultM_i;
            mipsPkg::FwdWb:  return fwdResultW_i;
            default:         return regVal;
        endcase
    endfunction

    assign opcode = instrD_i[31:26];
    assign funct  = instrD_i[5:0];
    assign rsD_o  = instrD_i[25:21];
    assign rtD_o  = instrD_i[20:16];

    always_comb begin
        aluOpD_o      = mipsPkg::AluAdd;
        writesReg     = 1'b0;
        useImm        = 1'b1;
        signExt       = 1'b1;
        useRd         = 1'b0;
        memReadD_o    = 1'b0;
        memWriteD_o   = 1'b0;
        byteAccessD_o = 1'b0;
        branchD_o     = 1'b0;
        branchNeD_o   = 1'b0;
        case (opcode)
            mipsPkg::OpSpecial: begin
                useImm    = 1'b0;
                useRd     = 1'b1;
                writesReg = 1'b1;
                case (funct)
                    mipsPkg::FnAddu: aluOpD_o = mipsPkg::AluAdd;
                    mipsPkg::FnSubu: aluOpD_o = mipsPkg::AluSub;
                    mipsPkg::FnAnd:  aluOpD_o = mipsPkg::AluAnd;
                    mipsPkg::FnOr:   aluOpD_o = mipsPkg::AluOr;
                    mipsPkg::FnXor:  aluOpD_o = mipsPkg::AluXor;
                    mipsPkg::FnSlt:  aluOpD_o = mipsPkg::AluSlt;
                    mipsPkg::FnSll:  aluOpD_o = mipsPkg::AluSll;
                    default:         writesReg = 1'b0; // unsupported funct acts as nop
                endcase
            end
            mipsPkg::OpAddiu: writesReg = 1'b1;
            mipsPkg::OpAndi: begin
                writesReg = 1'b1;
                signExt   = 1'b0;
                aluOpD_o  = mipsPkg::AluAnd;
            end
            mipsPkg::OpOri: begin
                writesReg = 1'b1;
                signExt   = 1'b0;
                aluOpD_o  = mipsPkg::AluOr;
            end
            mipsPkg::OpLui: begin
                writesReg = 1'b1;
                aluOpD_o  = mipsPkg::AluLui;
            end
            mipsPkg::OpBeq, mipsPkg::OpBne: begin
                useImm      = 1'b0; // compare uses rs and rt
                branchD_o   = 1'b1;
                branchNeD_o = (opcode == mipsPkg::OpBne);
            end
            mipsPkg::OpLw, mipsPkg::OpLbu: begin
                writesReg     = 1'b1;
                memReadD_o    = 1'b1;
                byteAccessD_o = (opcode == mipsPkg::OpLbu);
            end
            mipsPkg::OpSw, mipsPkg::OpSb: begin
                memWriteD_o   = 1'b1;
                byteAccessD_o = (opcode == mipsPkg::OpSb);
            end
            default: writesReg = 1'b0;
        endcase
    end

    assign immSign = {{16{instrD_i[15]}}, instrD_i[15:0]};
    assign immExt  = signExt ? immSign : {16'b0, instrD_i[15:0]};

    assign writeRegD_o = useRd ? instrD_i[15:11] : rtD_o;
    assign regWriteD_o = writesReg && (writeRegD_o != '0); // writes to $0 are dropped

    assign srcAD_o    = pickFwd(fwdSel1D_i, rd1D_i);
    assign rtValueD_o = pickFwd(fwdSel2D_i, rd2D_i);
    assign srcBD_o    = useImm ? immExt : rtValueD_o;

    // relative to the delay slot
    assign branchTargetD_o = pcD_i + 32'd4 + {immSign[29:0], 2'b00};

endmodule

// File: rtl/fetchUnit.sv
module fetchUnit #(
    parameter mipsPkg::wordT ResetPc = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          reset_i,
    input  logic          stallF_i,
    input  logic          stallD_i,
    input  logic          flushD_i,
    input  logic          takeE_i,
    input  mipsPkg::wordT branchTargetE_i,
    input  mipsPkg::wordT instrF_i,
    output mipsPkg::wordT instAddrF_o,
    output logic          instEnF_o,
    output mipsPkg::wordT pcD_o,
    output mipsPkg::wordT instrD_o
);

    mipsPkg::wordT pcF;
    mipsPkg::wordT pcNext;

    // predict not taken, redirect once the branch resolves in execute
    assign pcNext = takeE_i ? branchTargetE_i : pcF + 32'd4;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pcF <= ResetPc;
        end else if (!stallF_i) begin
            pcF <= pcNext;
        end
    end

    assign instAddrF_o = pcF;
    assign instEnF_o   = ~flushD_i; // slot after the delay slot is dropped

    always_ff @(posedge clk) begin
        if (reset_i) begin
            instrD_o <= '0; // all zero is a nop
        end else if (!stallD_i) begin
            instrD_o <= flushD_i ? '0 : instrF_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallD_i) begin
            pcD_o <= pcF;
        end
    end

    // branch targets and reset value must keep fetch on word boundaries
    pcAligned: assert property (@(posedge clk) disable iff (reset_i)
        instAddrF_o[1:0] == 2'b00);

endmodule

// File: rtl/mipsPkg.sv
package mipsPkg;

    typedef logic [31:0] wordT;   // data or address word
    typedef logic [4:0]  regIdxT; // register number
    typedef logic [3:0]  byteEnT; // store byte lanes

    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluSlt,
        AluSll,
        AluLui
    } aluOpT;

    // operand source picked in decode, newest first after FwdReg
    typedef enum logic [1:0] {
        FwdReg,
        FwdExe,
        FwdMem,
        FwdWb
    } fwdSelT;

    localparam logic [5:0] OpSpecial = 6'h00;
    localparam logic [5:0] OpBeq     = 6'h04;
    localparam logic [5:0] OpBne     = 6'h05;
    localparam logic [5:0] OpAddiu   = 6'h09;
    localparam logic [5:0] OpAndi    = 6'h0c;
    localparam logic [5:0] OpOri     = 6'h0d;
    localparam logic [5:0] OpLui     = 6'h0f;
    localparam logic [5:0] OpLw      = 6'h23;
    localparam logic [5:0] OpLbu     = 6'h24;
    localparam logic [5:0] OpSb      = 6'h28;
    localparam logic [5:0] OpSw      = 6'h2b;

    localparam logic [5:0] FnSll  = 6'h00;
    localparam logic [5:0] FnAddu = 6'h21;
    localparam logic [5:0] FnSubu = 6'h23;
    localparam logic [5:0] FnAnd  = 6'h24;
    localparam logic [5:0] FnOr   = 6'h25;
    localparam logic [5:0] FnXor  = 6'h26;
    localparam logic [5:0] FnSlt  = 6'h2a;

endpackage
